// ==== tb.f ====
ucode_pkg.sv
opcode_classifier.sv
idx_postbyte_decoder.sv
ucode_rom.sv
ucode_sequencer.sv
ucode_ctrl.sv
tb_ucode_ctrl.sv

// ==== Makefile ====
TOP := tb_ucode_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^All tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_ucode_ctrl.sv ====
`timescale 1ns/100ps

module tb_ucode_ctrl;

    logic        clk, rst, cen;
    logic [7:0]  op;
    logic [15:0] mdata;
    logic        mem_busy, stack_busy, irq_n, nmi_n, firq_n;
    logic [3:0]  intvec;
    logic [2:0]  idx_rsel;
    logic [1:0]  idx_asel;
    logic        idx_post, idx_ld, idx_acc, idxw;
    logic        ni, we, memhi, opd, up_ld8, up_ld16, up_cc, psh_go, pul_go;
    logic        set_pc_branch8, set_pc_branch16, pc_jmp, int_en, buserror;
    logic [8:0]  strobes;

    ucode_ctrl i_ucode_ctrl (.*);

    assign strobes = {we, up_ld8, up_ld16, up_cc, psh_go, pul_go,
                      set_pc_branch8, set_pc_branch16, pc_jmp};

    string strobe_name [9] = '{"pc_jmp", "set_pc_branch16", "set_pc_branch8", "pul_go",
                               "psh_go", "up_cc", "up_ld16", "up_ld8", "we"};
    logic [7:0] plain_ops [9] = '{ucode_pkg::LDA_IMM, ucode_pkg::ADDA_IMM, ucode_pkg::LDD_IMM,
                                  ucode_pkg::INCA, ucode_pkg::BRA, ucode_pkg::LBRA,
                                  ucode_pkg::PUSHS, ucode_pkg::PULLS, ucode_pkg::NOP};
    logic [7:0] idx_ops [3] = '{ucode_pkg::LDA_IDX, ucode_pkg::STA, ucode_pkg::JMP};

    int    n_plain = 80, n_irq = 80, n_idx = 80, n_mix = 120;
    int    errors = 0, checks = 0;
    string test_name = "reset";

    // expectations for the routine in flight
    int         exp_len, int_row;
    logic [3:0] exp_state;
    logic [8:0] exp_strb;
    logic       idx_on;
    logic       stall_on = 1'b0;
    logic [7:0] cur_op, cur_pb, nxt_op, nxt_pb;
    int         cur_kind, nxt_kind;  // 0 opcode, 1 nmi, 2 firq, 3 irq

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 40 cycles allowed per instruction
    initial begin
        #((n_plain + n_irq + n_idx + n_mix + 2) * 40 * 4);
        $display("timeout: the run did not reach its end before the watchdog expired");
        $display("Some tests failed");
        $finish;
    end

    task automatic check_ni(input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s ni: expected %b actual %b at %0t", test_name, exp, act, $time);
        end
    endtask

    task automatic check_intvec(input logic [3:0] exp, input logic [3:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s intvec: expected %b actual %b at %0t",
                     test_name, exp, act, $time);
        end
    endtask

    task automatic check_idx(input logic [2:0] exp_r, input logic [1:0] exp_a,
                             input logic [2:0] act_r, input logic [1:0] act_a);
        checks++;
        if (act_r !== exp_r || act_a !== exp_a) begin
            errors++;
            $display("error %s idx_rsel/idx_asel: expected %b/%b actual %b/%b at %0t",
                     test_name, exp_r, exp_a, act_r, act_a, $time);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s %s: expected %b actual %b at %0t",
                     test_name, what, exp, act, $time);
        end
    endtask

    task automatic check_strobes();
        int i;
        for (i = 0; i < 9; i++) begin
            check_flag(strobe_name[i], exp_strb[i], strobes[i]);
        end
    endtask

    // addressing routine length per postbyte mode or 0 when unsupported
    function automatic int addr_len(input logic [7:0] pb);
        case ({pb[7], pb[2:0]})
            4'b0110:                   return 1;   // ,R
            4'b0000, 4'b0001, 4'b0100, 4'b1100,
            4'b1000, 4'b1001, 4'b1111: return 2;
            4'b0101, 4'b0111:          return 3;   // 16-bit offset or extended
            default:                   return 0;
        endcase
    endfunction

    // length of the routine that ends the instruction
    function automatic int final_len(input logic [7:0] opc);
        case (opc)
            ucode_pkg::LDD_IMM, ucode_pkg::LBRA: return 3;
            ucode_pkg::INCA, ucode_pkg::NOP,
            ucode_pkg::JMP:                      return 1;
            default:                             return 2;
        endcase
    endfunction

    // index into strobes of the one expected with ni
    function automatic int ni_strobe(input logic [7:0] opc);
        case (opc)
            ucode_pkg::LDA_IMM, ucode_pkg::ADDA_IMM,
            ucode_pkg::INCA, ucode_pkg::LDA_IDX: return 7;
            ucode_pkg::LDD_IMM:                  return 6;
            ucode_pkg::PUSHS:                    return 4;
            ucode_pkg::PULLS:                    return 3;
            ucode_pkg::BRA:                      return 2;
            ucode_pkg::LBRA:                     return 1;
            ucode_pkg::JMP:                      return 0;
            ucode_pkg::STA:                      return 8;   // we
            default:                             return -1;  // nop
        endcase
    endfunction

    function automatic logic is_idx(input logic [7:0] opc);
        return opc == ucode_pkg::LDA_IDX || opc == ucode_pkg::STA || opc == ucode_pkg::JMP;
    endfunction

    function automatic logic legal_op(input logic [7:0] opc);
        case (opc)
            ucode_pkg::LDA_IMM, ucode_pkg::ADDA_IMM, ucode_pkg::LDD_IMM, ucode_pkg::INCA,
            ucode_pkg::BRA, ucode_pkg::LBRA, ucode_pkg::PUSHS, ucode_pkg::PULLS,
            ucode_pkg::NOP, ucode_pkg::LDA_IDX, ucode_pkg::STA, ucode_pkg::JMP: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic predict(input int kind, input logic [7:0] opc, input logic [7:0] pb);
        exp_state = 4'b0000;
        int_row   = 99;
        idx_on    = 1'b0;
        exp_strb  = '0;
        if (kind != 0) begin
            exp_len   = 4;
            exp_state = 4'b1000 >> kind;  // nmi 0100, firq 0010, irq 0001
            int_row   = 0;
            exp_strb  = 9'b000100000;     // up_cc
        end else begin
            exp_len = final_len(opc);
            if (ni_strobe(opc) >= 0) exp_strb = 9'd1 << ni_strobe(opc);
            if (is_idx(opc)) begin
                idx_on  = 1'b1;
                exp_len = exp_len + 1 + addr_len(pb) + (pb[3] ? 3 : 0);
            end
        end
    endtask

    // mode 0 plain, 1 interrupts, 2 indexed, 3 mixed, 4 illegal
    task automatic pick_next(input int mode);
        nxt_kind = 0;
        nxt_op   = plain_ops[4'($urandom % 9)];
        nxt_pb   = 8'($urandom);
        while (addr_len(nxt_pb) == 0) nxt_pb = 8'($urandom);
        if ((mode == 1 || mode == 3) && $urandom % 2 == 0) nxt_kind = 1 + int'($urandom % 3);
        if ((mode == 2 || mode == 3) && $urandom % 4 != 0) nxt_op = idx_ops[2'($urandom % 3)];
        if (mode == 4) begin
            nxt_op = 8'($urandom);
            while (legal_op(nxt_op)) nxt_op = 8'($urandom);
        end
    endtask

    // one routine with the next one's interrupt lines asserted from a random row on
    task automatic run_routine();
        int   row;
        int   assert_row;
        logic go;
        logic done;
        row        = 0;
        done       = 1'b0;
        assert_row = $urandom % exp_len;
        while (!done) begin
            @(posedge clk);
            #0.5;
            rst        = 1'b0;
            op         = nxt_op;
            mdata      = {8'($urandom), cur_pb};
            cen        = !stall_on || ($urandom % 8 != 0);
            mem_busy   = stall_on && ($urandom % 6 == 0);
            stack_busy = stall_on && ($urandom % 6 == 0);
            {nmi_n, firq_n, irq_n} = 3'b111;
            if (row >= assert_row) begin
                case (nxt_kind)
                    1:       {nmi_n, firq_n, irq_n} = {1'b0, 2'($urandom)};
                    2:       {nmi_n, firq_n, irq_n} = {2'b10, 1'($urandom)};
                    3:       {nmi_n, firq_n, irq_n} = 3'b110;
                    default: {nmi_n, firq_n, irq_n} = 3'b111;
                endcase
            end
            @(negedge clk);
            check_ni(row == exp_len - 1, ni);
            check_flag("int_en", row >= int_row, int_en);
            check_intvec(row >= int_row ? exp_state : 4'b0000, intvec);
            check_flag("buserror", 1'b0, buserror);
            if (row == exp_len - 1) begin
                check_strobes();
                check_flag("memhi", 1'b0, memhi);
                check_flag("opd", 1'b0, opd);
                if (idx_on) check_idx(cur_pb[6:4], cur_pb[1:0], idx_rsel, idx_asel);
            end
            go = cen && !mem_busy && !stack_busy;  // stalled cycles repeat the row
            if (go && row == exp_len - 1) done = 1'b1;
            else if (go) row++;
        end
    endtask

    task automatic run_phase(input string name, input int n, input int mode);
        test_name = name;
        repeat (n) begin
            cur_kind = nxt_kind;
            cur_op   = nxt_op;
            cur_pb   = nxt_pb;
            pick_next(mode);
            predict(cur_kind, cur_op, cur_pb);
            run_routine();
        end
    endtask

    initial begin
        void'($urandom(32'h5f70_f906));
        rst        = 1'b1;
        cen        = 1'b1;
        op         = ucode_pkg::NOP;
        mdata      = '0;
        mem_busy   = 1'b0;
        stack_busy = 1'b0;
        irq_n      = 1'b1;
        nmi_n      = 1'b1;
        firq_n     = 1'b1;
        exp_strb   = '0;
        repeat (16) begin
            @(posedge clk);
            #0.5;
            rst = 1'b1;
            @(negedge clk);
            check_ni(1'b0, ni);
            check_intvec(4'b0000, intvec);
            check_strobes();
            check_flag("memhi", 1'b0, memhi);
            check_flag("opd", 1'b0, opd);
            check_flag("int_en", 1'b0, int_en);
            check_flag("buserror", 1'b0, buserror);
            check_flag("idx_post", 1'b0, idx_post);
            check_flag("idx_ld", 1'b0, idx_ld);
            check_flag("idx_acc", 1'b0, idx_acc);
            check_flag("idxw", 1'b0, idxw);
        end

        // reset routine where the vector rows show intvec 1000
        pick_next(0);
        cur_pb    = 8'h00;
        exp_len   = 3;
        exp_state = 4'b1000;
        int_row   = 1;
        exp_strb  = 9'b000000001;  // pc_jmp
        idx_on    = 1'b0;
        run_routine();

        run_phase("plain", n_plain, 0);
        run_phase("interrupt", n_irq, 1);
        run_phase("indexed", n_idx, 2);
        stall_on = 1'b1;
        run_phase("stall", n_mix, 3);
        run_phase("stall", 1, 4);  // last routine hands over to an illegal opcode

        test_name = "buserror";
        repeat (20) begin
            @(posedge clk);
            #0.5;
            nmi_n = 1'($urandom);
            op    = plain_ops[4'($urandom % 9)];
            @(negedge clk);
            check_flag("buserror", 1'b1, buserror);
            check_ni(1'b0, ni);
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== ucode_ctrl.sv ====
`timescale 1ns/100ps

module ucode_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:0]  op,
    input  logic [15:0] mdata,
    input  logic        mem_busy,
    input  logic        stack_busy,
    input  logic        irq_n,
    input  logic        nmi_n,
    input  logic        firq_n,
    output logic [3:0]  intvec,
    output logic [2:0]  idx_rsel,
    output logic [1:0]  idx_asel,
    output logic        idx_post,
    output logic        idx_ld,
    output logic        idx_acc,
    output logic        idxw,
    output logic        ni, we, memhi, opd,
    output logic        up_ld8, up_ld16, up_cc,
    output logic        psh_go, pul_go,
    output logic        set_pc_branch8, set_pc_branch16, pc_jmp,
    output logic        int_en, buserror
);

    logic [ucode_pkg::OPCAT_AW-1:0] opcat;
    logic [ucode_pkg::OPCAT_AW-1:0] nx_cat;
    logic [ucode_pkg::OPCAT_AW-1:0] idx_cat;
    logic [ucode_pkg::UCODE_AW-1:0] row_addr;
    ucode_pkg::ucode_word_u         ucode_word;

    opcode_classifier u_classifier (
        .op     (op),
        .opcat  (opcat),
        .nx_cat (nx_cat)
    );

    // postbyte sits in the low data byte
    idx_postbyte_decoder u_postbyte (
        .postbyte (mdata[7:0]),
        .idx_cat  (idx_cat)
    );

    ucode_rom u_rom (
        .row_addr   (row_addr),
        .ucode_word (ucode_word)
    );

    ucode_sequencer u_sequencer (
        .postbyte (mdata[7:0]),
        .op_bit4  (op[4]),
        .*
    );

endmodule

// ==== ucode_sequencer.sv ====
`timescale 1ns/100ps

module ucode_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           cen,
    input  ucode_pkg::ucode_word_u         ucode_word,
    input  logic [ucode_pkg::OPCAT_AW-1:0] opcat,
    input  logic [ucode_pkg::OPCAT_AW-1:0] nx_cat,
    input  logic [ucode_pkg::OPCAT_AW-1:0] idx_cat,
    input  logic [7:0]                     postbyte,
    input  logic                           op_bit4,
    input  logic                           mem_busy,
    input  logic                           stack_busy,
    input  logic                           irq_n,
    input  logic                           nmi_n,
    input  logic                           firq_n,
    output logic [ucode_pkg::UCODE_AW-1:0] row_addr,
    output logic [3:0]                     intvec,
    output logic [2:0]                     idx_rsel,
    output logic [1:0]                     idx_asel,
    output logic                           idx_post,
    output logic                           idx_ld,
    output logic                           idx_acc,
    output logic                           idxw,
    output logic                           ni, we, memhi, opd,
    output logic                           up_ld8, up_ld16, up_cc,
    output logic                           psh_go, pul_go,
    output logic                           set_pc_branch8, set_pc_branch16, pc_jmp,
    output logic                           int_en, buserror
);

    logic [ucode_pkg::OPCAT_AW-1:0] nx_catl;    // final routine after indexing
    logic [ucode_pkg::UCODE_AW-1:0] step;
    logic [3:0]                     cur_int;
    logic [1:0]                     seq_op;
    logic                           seq_row;
    logic                           idx_ind_rq, idx_postl;
    logic                           idx_jmp, idx_ind, idx_ret;
    logic                           skip_noind, set_idx_post, set_idxw, set_idx_acc;
    logic                           stall;

    // seq rows only carry ni, opd and memhi
    assign seq_row = ucode_word.ctrl.fmt;
    assign seq_op  = seq_row ? ucode_word.seq.op : ucode_pkg::SEQ_NONE;
    assign idx_jmp = seq_op == ucode_pkg::SEQ_IDX_JMP;
    assign idx_ind = seq_op == ucode_pkg::SEQ_IDX_IND;
    assign idx_ret = seq_op == ucode_pkg::SEQ_IDX_RET;

    assign ni    = seq_row ? ucode_word.seq.ni    : ucode_word.ctrl.ni;
    assign opd   = ucode_word.ctrl.opd;  // same bit in both views
    assign memhi = seq_row ? ucode_word.seq.memhi : ucode_word.ctrl.memhi;

    assign {we, up_ld8, up_ld16, up_cc, psh_go, pul_go} = seq_row ? 6'd0 :
        {ucode_word.ctrl.we, ucode_word.ctrl.up_ld8, ucode_word.ctrl.up_ld16,
         ucode_word.ctrl.up_cc, ucode_word.ctrl.psh_go, ucode_word.ctrl.pul_go};
    assign {set_pc_branch8, set_pc_branch16, pc_jmp, int_en, buserror} = seq_row ? 5'd0 :
        {ucode_word.ctrl.set_pc_branch8, ucode_word.ctrl.set_pc_branch16,
         ucode_word.ctrl.pc_jmp, ucode_word.ctrl.int_en, ucode_word.ctrl.buserror};
    assign {skip_noind, set_idx_post, set_idxw, set_idx_acc} = seq_row ? 4'd0 :
        {ucode_word.ctrl.skip_noind, ucode_word.ctrl.set_idx_post,
         ucode_word.ctrl.set_idxw, ucode_word.ctrl.set_idx_acc};

    assign intvec = cur_int & {4{int_en}};
    assign stall  = mem_busy | stack_busy;
    assign step   = (skip_noind && !op_bit4) ? 8'd2 : 8'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            row_addr   <= {ucode_pkg::RESET, ucode_pkg::ROW0};
            cur_int    <= 4'b1000;
            nx_catl    <= '0;
            idx_rsel   <= '0;
            idx_asel   <= '0;
            idx_ind_rq <= 1'b0;
            idx_postl  <= 1'b0;
            idx_post   <= 1'b0;
            idx_ld     <= 1'b0;
            idx_acc    <= 1'b0;
            idxw       <= 1'b0;
        end else if (cen && !buserror) begin   // bus error freezes everything
            idx_post <= 1'b0;
            idx_ld   <= 1'b0;
            if (!stall) begin
                row_addr <= row_addr + step;
                idx_acc  <= set_idx_acc;
                if (set_idx_post) idx_postl <= 1'b1;
                if (set_idxw) idxw <= 1'b1;

                if (ni) begin
                    nx_catl <= nx_cat;
                    if (!nmi_n) begin
                        cur_int  <= 4'b0100;
                        row_addr <= {ucode_pkg::NMI, ucode_pkg::ROW0};
                    end else if (!firq_n) begin
                        cur_int  <= 4'b0010;
                        row_addr <= {ucode_pkg::FIRQ, ucode_pkg::ROW0};
                    end else if (!irq_n) begin
                        cur_int  <= 4'b0001;
                        row_addr <= {ucode_pkg::IRQ, ucode_pkg::ROW0};
                    end else begin
                        cur_int  <= 4'b0000;
                        row_addr <= {opcat, ucode_pkg::ROW0};
                    end
                end

                if (idx_jmp) begin
                    row_addr   <= {idx_cat, ucode_pkg::ROW0};
                    idx_rsel   <= postbyte[6:4];
                    idx_asel   <= postbyte[1:0];
                    idx_ind_rq <= postbyte[3];
                end
                if (idx_ind) begin
                    row_addr  <= idx_ind_rq ? {ucode_pkg::IDX_IND, ucode_pkg::ROW0}
                                            : {nx_catl, ucode_pkg::ROW0};
                    idx_post  <= idx_postl;  // register update happens once here
                    idx_postl <= 1'b0;
                    idx_ld    <= !idx_ind_rq;
                    if (!idx_ind_rq) idxw <= 1'b0;
                end
                if (idx_ret) begin
                    row_addr   <= {nx_catl, ucode_pkg::ROW0};
                    idx_ind_rq <= 1'b0;
                    idx_ld     <= 1'b1; // pointer fetched from memory
                    idxw       <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== ucode_rom.sv ====
`timescale 1ns/100ps

module ucode_rom (
    input  logic [ucode_pkg::UCODE_AW-1:0] row_addr,
    output ucode_pkg::ucode_word_u         ucode_word
);

    always_comb begin
        ucode_word = '0;
        case (row_addr)
            {ucode_pkg::RESET, 3'd0},
            {ucode_pkg::NOPE, 3'd0}:     ucode_word.ctrl.fmt = 1'b0; // no strobes
            {ucode_pkg::RESET, 3'd1}:    ucode_word.ctrl.memhi = 1'b1; // vector high byte
            {ucode_pkg::RESET, 3'd2}:    ucode_word.ctrl.pc_jmp = 1'b1;

            // interrupt entry, same shape for all three
            {ucode_pkg::NMI, 3'd0}, {ucode_pkg::FIRQ, 3'd0},
            {ucode_pkg::IRQ, 3'd0}:      ucode_word.ctrl.psh_go = 1'b1;
            {ucode_pkg::NMI, 3'd1}, {ucode_pkg::FIRQ, 3'd1},
            {ucode_pkg::IRQ, 3'd1}:      ucode_word.ctrl.memhi = 1'b1;
            {ucode_pkg::NMI, 3'd2}, {ucode_pkg::FIRQ, 3'd2},
            {ucode_pkg::IRQ, 3'd2}:      ucode_word.ctrl.pc_jmp = 1'b1;
            {ucode_pkg::NMI, 3'd3}, {ucode_pkg::FIRQ, 3'd3},
            {ucode_pkg::IRQ, 3'd3}:      ucode_word.ctrl.up_cc = 1'b1; // mask bits

            // operand fetch rows
            {ucode_pkg::ALU8_IMM, 3'd0}, {ucode_pkg::ALU16_IMM, 3'd0},
            {ucode_pkg::BRANCH8, 3'd0}, {ucode_pkg::BRANCH16, 3'd0},
            {ucode_pkg::PUSH, 3'd0}, {ucode_pkg::PULL, 3'd0},
            {ucode_pkg::LOAD8_IDX, 3'd0}, {ucode_pkg::IDX_OFFSET8, 3'd0},
            {ucode_pkg::IDX_DP, 3'd0},
            {ucode_pkg::IDX_OFFSET16, 3'd1}, {ucode_pkg::IDX_EXT, 3'd1}:
                                         ucode_word.ctrl.opd = 1'b1;
            {ucode_pkg::ALU16_IMM, 3'd1},
            {ucode_pkg::BRANCH16, 3'd1},
            {ucode_pkg::IDX_IND, 3'd1}:  ucode_word.ctrl.memhi = 1'b1;

            {ucode_pkg::ALU8_IMM, 3'd1},
            {ucode_pkg::INH_A, 3'd0},
            {ucode_pkg::LOAD8_IDX, 3'd1}: ucode_word.ctrl.up_ld8 = 1'b1;
            {ucode_pkg::ALU16_IMM, 3'd2}: ucode_word.ctrl.up_ld16 = 1'b1;
            {ucode_pkg::BRANCH8, 3'd1}:   ucode_word.ctrl.set_pc_branch8 = 1'b1;
            {ucode_pkg::BRANCH16, 3'd2}:  ucode_word.ctrl.set_pc_branch16 = 1'b1;
            {ucode_pkg::PUSH, 3'd1}:      ucode_word.ctrl.psh_go = 1'b1;
            {ucode_pkg::PULL, 3'd1}:      ucode_word.ctrl.pul_go = 1'b1;
            {ucode_pkg::STORE8, 3'd0}:    ucode_word.ctrl.up_cc = 1'b1;
            {ucode_pkg::STORE8, 3'd1}:    ucode_word.ctrl.we = 1'b1;
            {ucode_pkg::JUMP, 3'd0}:      ucode_word.ctrl.pc_jmp = 1'b1;

            // indexed address build
            {ucode_pkg::IDX_RINC, 3'd0}:  ucode_word.ctrl.set_idx_post = 1'b1;
            {ucode_pkg::IDX_ACC, 3'd0}:   ucode_word.ctrl.set_idx_acc = 1'b1;
            {ucode_pkg::IDX_OFFSET16, 3'd0}, {ucode_pkg::IDX_EXT, 3'd0},
            {ucode_pkg::IDX_IND, 3'd0}:   ucode_word.ctrl.set_idxw = 1'b1; // 16-bit fetch

            {ucode_pkg::PARSE_IDX, 3'd0}: begin
                ucode_word.seq.fmt = 1'b1;
                ucode_word.seq.op  = ucode_pkg::SEQ_IDX_JMP;
                ucode_word.seq.opd = 1'b1; // postbyte on the bus
            end
            {ucode_pkg::IDX_R, 3'd0}, {ucode_pkg::IDX_RINC, 3'd1},
            {ucode_pkg::IDX_OFFSET8, 3'd1}, {ucode_pkg::IDX_OFFSET16, 3'd2},
            {ucode_pkg::IDX_EXT, 3'd2}, {ucode_pkg::IDX_DP, 3'd1},
            {ucode_pkg::IDX_ACC, 3'd1}: begin
                ucode_word.seq.fmt = 1'b1;
                ucode_word.seq.op  = ucode_pkg::SEQ_IDX_IND;
            end
            {ucode_pkg::IDX_IND, 3'd2}: begin
                ucode_word.seq.fmt = 1'b1;
                ucode_word.seq.op  = ucode_pkg::SEQ_IDX_RET;
            end

            default: ucode_word.ctrl.buserror = 1'b1; // unused rows trap
        endcase

        // last row of each ctrl routine
        if (row_addr inside {{ucode_pkg::RESET, 3'd2}, {ucode_pkg::NMI, 3'd3},
                {ucode_pkg::FIRQ, 3'd3}, {ucode_pkg::IRQ, 3'd3},
                {ucode_pkg::ALU8_IMM, 3'd1}, {ucode_pkg::ALU16_IMM, 3'd2},
                {ucode_pkg::INH_A, 3'd0}, {ucode_pkg::BRANCH8, 3'd1},
                {ucode_pkg::BRANCH16, 3'd2}, {ucode_pkg::PUSH, 3'd1},
                {ucode_pkg::PULL, 3'd1}, {ucode_pkg::NOPE, 3'd0},
                {ucode_pkg::LOAD8_IDX, 3'd1}, {ucode_pkg::STORE8, 3'd1},
                {ucode_pkg::JUMP, 3'd0}}) begin
            ucode_word.ctrl.ni = 1'b1;
        end

        // vector fetch rows expose intvec
        if ((row_addr[7:3] inside {ucode_pkg::NMI, ucode_pkg::FIRQ, ucode_pkg::IRQ}
                && !row_addr[2])
                || row_addr inside {{ucode_pkg::RESET, 3'd1}, {ucode_pkg::RESET, 3'd2}}) begin
            ucode_word.ctrl.int_en = 1'b1;
        end
    end

endmodule

// ==== idx_postbyte_decoder.sv ====
`timescale 1ns/100ps

module idx_postbyte_decoder (
    input  logic [7:0]                     postbyte,
    output logic [ucode_pkg::OPCAT_AW-1:0] idx_cat
);

    // bit 7 splits register modes from dp/accumulator modes
    always_comb begin
        case ({postbyte[7], postbyte[2:0]})
            4'b0_000,
            4'b0_001: idx_cat = ucode_pkg::IDX_RINC;     // post increment by 1 or 2
            4'b0_100: idx_cat = ucode_pkg::IDX_OFFSET8;
            4'b0_101: idx_cat = ucode_pkg::IDX_OFFSET16;
            4'b0_110: idx_cat = ucode_pkg::IDX_R;
            4'b0_111: idx_cat = ucode_pkg::IDX_EXT;
            4'b1_100: idx_cat = ucode_pkg::IDX_DP;
            4'b1_000,
            4'b1_001,
            4'b1_111: idx_cat = ucode_pkg::IDX_ACC;      // a, b or d offset
            // pre decrement is not part of the reduced set
            default:  idx_cat = ucode_pkg::BUSERROR;
        endcase
    end

endmodule

// ==== opcode_classifier.sv ====
`timescale 1ns/100ps

module opcode_classifier (
    input  logic [7:0]                     op,
    output logic [ucode_pkg::OPCAT_AW-1:0] opcat,
    output logic [ucode_pkg::OPCAT_AW-1:0] nx_cat
);

    always_comb begin
        nx_cat = ucode_pkg::BUSERROR; // only read after indexed parsing
        case (op)
            ucode_pkg::LDA_IMM,
            ucode_pkg::ADDA_IMM: opcat = ucode_pkg::ALU8_IMM;
            ucode_pkg::LDD_IMM:  opcat = ucode_pkg::ALU16_IMM;
            ucode_pkg::INCA:     opcat = ucode_pkg::INH_A;
            ucode_pkg::BRA:      opcat = ucode_pkg::BRANCH8;
            ucode_pkg::LBRA:     opcat = ucode_pkg::BRANCH16;
            ucode_pkg::PUSHS:    opcat = ucode_pkg::PUSH;
            ucode_pkg::PULLS:    opcat = ucode_pkg::PULL;
            ucode_pkg::NOP:      opcat = ucode_pkg::NOPE;

            // operand through the postbyte
            ucode_pkg::LDA_IDX: begin
                opcat  = ucode_pkg::PARSE_IDX;
                nx_cat = ucode_pkg::LOAD8_IDX;
            end
            ucode_pkg::STA: begin
                opcat  = ucode_pkg::PARSE_IDX;
                nx_cat = ucode_pkg::STORE8;
            end
            ucode_pkg::JMP: begin
                opcat  = ucode_pkg::PARSE_IDX;
                nx_cat = ucode_pkg::JUMP;
            end

            default: opcat = ucode_pkg::BUSERROR; // illegal opcode
        endcase
    end

endmodule

// ==== ucode_pkg.sv ====
package ucode_pkg;

    localparam int UCODE_AW = 8;   // row address
    localparam int OPCAT_AW = 5;   // routine category
    localparam int UCODE_DW = 24;  // microcode word

    // first row of a routine, appended below the category
    localparam logic [UCODE_AW-OPCAT_AW-1:0] ROW0 = '0;

    // routine categories, each routine starts at cat*8
    localparam logic [OPCAT_AW-1:0] RESET        = 5'd0;
    localparam logic [OPCAT_AW-1:0] NMI          = 5'd1;
    localparam logic [OPCAT_AW-1:0] FIRQ         = 5'd2;
    localparam logic [OPCAT_AW-1:0] IRQ          = 5'd3;
    localparam logic [OPCAT_AW-1:0] ALU8_IMM     = 5'd4;
    localparam logic [OPCAT_AW-1:0] ALU16_IMM    = 5'd5;
    localparam logic [OPCAT_AW-1:0] INH_A        = 5'd6;
    localparam logic [OPCAT_AW-1:0] BRANCH8      = 5'd7;
    localparam logic [OPCAT_AW-1:0] BRANCH16     = 5'd8;
    localparam logic [OPCAT_AW-1:0] PUSH         = 5'd9;
    localparam logic [OPCAT_AW-1:0] PULL         = 5'd10;
    localparam logic [OPCAT_AW-1:0] NOPE         = 5'd11;
    localparam logic [OPCAT_AW-1:0] PARSE_IDX    = 5'd12;
    localparam logic [OPCAT_AW-1:0] LOAD8_IDX    = 5'd13;
    localparam logic [OPCAT_AW-1:0] STORE8       = 5'd14;
    localparam logic [OPCAT_AW-1:0] JUMP         = 5'd15;
    // addressing modes
    localparam logic [OPCAT_AW-1:0] IDX_R        = 5'd16;
    localparam logic [OPCAT_AW-1:0] IDX_RINC     = 5'd17;
    localparam logic [OPCAT_AW-1:0] IDX_OFFSET8  = 5'd18;
    localparam logic [OPCAT_AW-1:0] IDX_OFFSET16 = 5'd19;
    localparam logic [OPCAT_AW-1:0] IDX_EXT      = 5'd20;
    localparam logic [OPCAT_AW-1:0] IDX_DP       = 5'd21;
    localparam logic [OPCAT_AW-1:0] IDX_ACC      = 5'd22;
    localparam logic [OPCAT_AW-1:0] IDX_IND      = 5'd23;
    localparam logic [OPCAT_AW-1:0] BUSERROR     = 5'd24; // sink, left only by reset

    // reduced opcode set
    localparam logic [7:0] LDA_IMM  = 8'h86;
    localparam logic [7:0] ADDA_IMM = 8'h8b;
    localparam logic [7:0] LDD_IMM  = 8'hcc;
    localparam logic [7:0] INCA     = 8'h4c;
    localparam logic [7:0] BRA      = 8'h20;
    localparam logic [7:0] LBRA     = 8'h16;
    localparam logic [7:0] PUSHS    = 8'h34;
    localparam logic [7:0] PULLS    = 8'h35;
    localparam logic [7:0] NOP      = 8'h12;
    localparam logic [7:0] LDA_IDX  = 8'ha6;
    localparam logic [7:0] STA      = 8'ha7;
    localparam logic [7:0] JMP      = 8'h6e;

    // sequencing operation of a seq row
    localparam logic [1:0] SEQ_NONE    = 2'd0;
    localparam logic [1:0] SEQ_IDX_JMP = 2'd1; // dispatch on postbyte
    localparam logic [1:0] SEQ_IDX_IND = 2'd2; // indirect or final routine
    localparam logic [1:0] SEQ_IDX_RET = 2'd3; // back from indirect fetch

    // bit 23 picks the view
    typedef union packed {
        struct packed {
            logic fmt;  // 0 here
            logic ni;
            logic we;
            logic memhi;
            logic opd;
            logic up_ld8;
            logic up_ld16;
            logic up_cc;
            logic psh_go;
            logic pul_go;
            logic set_pc_branch8;
            logic set_pc_branch16;
            logic pc_jmp;
            logic int_en;
            logic buserror;
            logic skip_noind;
            logic set_idx_post;
            logic set_idxw;
            logic set_idx_acc;
            logic [UCODE_DW-20:0] spare;
        } ctrl;
        struct packed {
            logic fmt;  // 1 here
            logic [1:0] op;
            logic ni;
            logic opd;
            logic memhi;
            logic [UCODE_DW-7:0] spare;
        } seq;
    } ucode_word_u;

endpackage
